// ==== common/stepper_pkg.sv ====
// shared widths, register map and bus structs for the motion peripheral, imported by each block
`default_nettype none

package stepper_pkg;

  // plain widths with a meaning
  typedef logic [31:0] word_t;
  typedef logic [7:0] paddr_t;
  typedef logic [15:0] period_t;
  typedef logic [15:0] steps_t;
  typedef logic signed [31:0] position_t;
  typedef logic [7:0] spi_addr_t;

  // driver frame, address byte goes out first
  typedef struct packed {
    spi_addr_t addr;
    word_t data;
  } spi_frame_t;

  // byte offsets inside the peripheral
  localparam paddr_t REG_CTRL = 8'h00;
  localparam paddr_t REG_PERIOD = 8'h04;
  localparam paddr_t REG_COUNT = 8'h08;
  localparam paddr_t REG_POSITION = 8'h0C;
  localparam paddr_t REG_STATUS = 8'h10;
  localparam paddr_t REG_SPI_ADDR = 8'h14;
  localparam paddr_t REG_SPI_DATA = 8'h18;
  localparam paddr_t REG_SPI_RX_ADDR = 8'h1C;
  localparam paddr_t REG_SPI_RX_DATA = 8'h20;
  localparam paddr_t REG_LED = 8'h24;

  // decoded register select
  typedef enum logic [3:0] {
    REG_NONE,
    SEL_CTRL,
    SEL_PERIOD,
    SEL_COUNT,
    SEL_POSITION,
    SEL_STATUS,
    SEL_SPI_ADDR,
    SEL_SPI_DATA,
    SEL_SPI_RX_ADDR,
    SEL_SPI_RX_DATA,
    SEL_LED
  } reg_sel_e;

  // one legal access, valid in the access cycle only
  typedef struct packed {
    reg_sel_e sel;
    logic wr;
    word_t wdata;
  } reg_access_t;

  // move request towards the step engine
  typedef struct packed {
    logic start;
    logic dir;
    period_t period;
    steps_t count;
  } move_cmd_t;

  // transfer request towards the spi engine
  typedef struct packed {
    logic start;
    spi_frame_t frame;
  } spi_cmd_t;

endpackage

`default_nettype wire

// ==== logic/apb_decode.sv ====
// apb slave front end, turns access phases into register selects and flags illegal accesses
`default_nettype none
`timescale 1ns/1ps

module apb_decode
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  paddr_t      paddr,
  input  word_t       pwdata,
  output logic        pready,
  output logic        pslverr,
  output reg_access_t acc
);

  logic setup_q;
  logic access;
  logic read_only;
  logic err;
  reg_sel_e sel;

  // remember a setup phase, an access needs one in front of it
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  assign access = psel & penable & setup_q;

  // address map
  // only exact word offsets match, so misaligned ones fall to default
  always_comb begin
    sel = REG_NONE;
    read_only = 1'b0;
    case (paddr)
      REG_CTRL:        sel = SEL_CTRL;
      REG_PERIOD:      sel = SEL_PERIOD;
      REG_COUNT:       sel = SEL_COUNT;
      REG_POSITION: begin
        sel = SEL_POSITION;
        read_only = 1'b1;
      end
      REG_STATUS: begin
        sel = SEL_STATUS;
        read_only = 1'b1;
      end
      REG_SPI_ADDR:    sel = SEL_SPI_ADDR;
      REG_SPI_DATA:    sel = SEL_SPI_DATA;
      REG_SPI_RX_ADDR: begin
        sel = SEL_SPI_RX_ADDR;
        read_only = 1'b1;
      end
      REG_SPI_RX_DATA: begin
        sel = SEL_SPI_RX_DATA;
        read_only = 1'b1;
      end
      REG_LED:         sel = SEL_LED;
      default:         sel = REG_NONE;
    endcase
  end

  // unmapped address or write to a status register
  assign err = (sel == REG_NONE) | (read_only & pwrite);

  // no wait states
  assign pready = psel & penable;
  assign pslverr = access & err;

  // failed accesses reach the register block as REG_NONE
  assign acc.sel = (access & ~err) ? sel : REG_NONE;
  assign acc.wr = access & ~err & pwrite;
  assign acc.wdata = pwdata;

endmodule

`default_nettype wire

// ==== motion/step_generator.sv ====
// step/direction engine, issues a counted run of step pulses and keeps the signed position
`default_nettype none
`timescale 1ns/1ps

module step_generator
  import stepper_pkg::*;
(
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  move_cmd_t move,
  input  logic      drv_en,
  output logic      step,
  output logic      dir,
  output logic      moving,
  output position_t position
);

  typedef enum logic [1:0] {
    IDLE,
    HIGH,
    LOW
  } state_e;

  state_e state_q;
  period_t per_q;
  period_t half_q;
  period_t cnt_q;
  period_t per_eff;
  steps_t left_q;
  logic dir_q;
  position_t pos_q;

  // shortest usable period is two cycles
  assign per_eff = (move.period < period_t'(2)) ? period_t'(2) : move.period;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q <= '0;
      left_q <= '0;
      dir_q <= 1'b0;
      pos_q <= '0;
    end else if ((state_q != IDLE) && !drv_en) begin
      // driver switched off, drop the move
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // zero count or disabled driver starts nothing
          if (move.start && drv_en && (move.count != '0)) begin
            state_q <= HIGH;
            per_q <= per_eff;
            half_q <= per_eff >> 1;
            cnt_q <= '0;
            left_q <= move.count;
            dir_q <= move.dir;
            // first rising edge shows up with this update
            pos_q <= move.dir ? pos_q + 32'sd1 : pos_q - 32'sd1;
          end
        end
        HIGH: begin
          cnt_q <= cnt_q + period_t'(1);
          if (cnt_q == half_q - period_t'(1)) begin
            state_q <= LOW;
          end
        end
        LOW: begin
          if (cnt_q == per_q - period_t'(1)) begin
            if (left_q == steps_t'(1)) begin
              // last period done
              state_q <= IDLE;
            end else begin
              state_q <= HIGH;
              cnt_q <= '0;
              left_q <= left_q - steps_t'(1);
              pos_q <= dir_q ? pos_q + 32'sd1 : pos_q - 32'sd1;
            end
          end else begin
            cnt_q <= cnt_q + period_t'(1);
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // step drops in the same cycle the driver is disabled
  assign step = (state_q == HIGH) & drv_en;
  // pin follows the control bit while idle, held during a move
  assign dir = (state_q == IDLE) ? move.dir : dir_q;
  assign moving = (state_q != IDLE);
  assign position = pos_q;

endmodule

`default_nettype wire

// ==== spi/spi_master.sv ====
// spi mode 3 master for the smart stepper driver, one 40-bit frame per start pulse
`default_nettype none
`timescale 1ns/1ps

module spi_master
  import stepper_pkg::*;
#(
  parameter int SPI_DIV = 4
) (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  spi_cmd_t   spi,
  input  logic       sdo,
  output logic       sck,
  output logic       cs_n,
  output logic       sdi,
  output logic       spi_busy,
  output spi_frame_t rx_frame
);

  localparam int FRAME_W = $bits(spi_frame_t);
  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
  localparam int BIT_W = $clog2(FRAME_W);

  typedef enum logic [1:0] {
    IDLE,
    SELECT,
    SHIFT,
    DESELECT
  } state_e;

  state_e state_q;
  logic [DIV_W-1:0] div_q;
  logic [BIT_W-1:0] bit_q;
  logic [FRAME_W-1:0] shift_q;
  logic sck_q;
  logic sdo_q;
  logic half_done;

  // end of one sck half period
  assign half_done = (div_q == DIV_W'(SPI_DIV - 1));

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state_q <= IDLE;
      div_q <= '0;
      bit_q <= '0;
      sck_q <= 1'b1;
      rx_frame <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          sck_q <= 1'b1;
          if (spi.start) begin
            state_q <= SELECT;
            shift_q <= spi.frame;
          end
        end
        SELECT: begin
          // msb already on sdi, first falling edge keeps it
          state_q <= SHIFT;
          sck_q <= 1'b0;
          div_q <= '0;
          bit_q <= '0;
        end
        SHIFT: begin
          if (half_done) begin
            div_q <= '0;
            if (!sck_q) begin
              // rising edge, sample the reply
              sck_q <= 1'b1;
              sdo_q <= sdo;
              if (bit_q == BIT_W'(FRAME_W - 1)) begin
                state_q <= DESELECT;
              end
            end else begin
              // falling edge, next bit out and last sample in
              sck_q <= 1'b0;
              shift_q <= {shift_q[FRAME_W-2:0], sdo_q};
              bit_q <= bit_q + BIT_W'(1);
            end
          end else begin
            div_q <= div_q + DIV_W'(1);
          end
        end
        DESELECT: begin
          // hold sck high one half period before releasing cs
          if (half_done) begin
            state_q <= IDLE;
            div_q <= '0;
            rx_frame <= {shift_q[FRAME_W-2:0], sdo_q};
          end else begin
            div_q <= div_q + DIV_W'(1);
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign sck = sck_q;
  assign cs_n = (state_q == IDLE);
  assign spi_busy = (state_q != IDLE);
  // sdi parked low while deselected
  assign sdi = cs_n ? 1'b0 : shift_q[FRAME_W-1];

endmodule

`default_nettype wire

// ==== logic/control_regs.sv ====
// register file of the peripheral that issues move and spi starts and forms apb read data
`default_nettype none
`timescale 1ns/1ps

module control_regs
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        rst_n,
  input  reg_access_t acc,
  input  logic        moving,
  input  logic        spi_busy,
  input  position_t   position,
  input  spi_frame_t  rx_frame,
  output word_t       prdata,
  output logic        drv_en,
  output move_cmd_t   move,
  output spi_cmd_t    spi,
  output logic [3:0]  led
);

  logic [1:0] ctrl_q;
  period_t period_q;
  steps_t count_q;
  spi_addr_t spi_addr_q;
  word_t spi_data_q;
  logic [3:0] led_q;
  logic move_start_q;
  logic spi_start_q;
  logic wr_count;
  logic wr_spi_data;

  assign wr_count = acc.wr & (acc.sel == SEL_COUNT);
  assign wr_spi_data = acc.wr & (acc.sel == SEL_SPI_DATA);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      ctrl_q <= '0;
      period_q <= '0;
      count_q <= '0;
      spi_addr_q <= '0;
      spi_data_q <= '0;
      led_q <= '0;
      move_start_q <= 1'b0;
      spi_start_q <= 1'b0;
    end else begin
      // busy engines or a disabled driver swallow the start
      move_start_q <= wr_count & ctrl_q[0] & ~moving;
      spi_start_q <= wr_spi_data & ~spi_busy;
      if (acc.wr) begin
        case (acc.sel)
          SEL_CTRL:     ctrl_q <= acc.wdata[1:0];
          SEL_PERIOD:   period_q <= acc.wdata[15:0];
          SEL_COUNT:    count_q <= acc.wdata[15:0];
          SEL_SPI_ADDR: spi_addr_q <= acc.wdata[7:0];
          SEL_SPI_DATA: spi_data_q <= acc.wdata;
          SEL_LED:      led_q <= acc.wdata[3:0];
          default:      ;
        endcase
      end
    end
  end

  // read mux with zero for REG_NONE
  always_comb begin
    case (acc.sel)
      SEL_CTRL:        prdata = word_t'(ctrl_q);
      SEL_PERIOD:      prdata = word_t'(period_q);
      SEL_COUNT:       prdata = word_t'(count_q);
      SEL_POSITION:    prdata = word_t'(position);
      SEL_STATUS:      prdata = word_t'({spi_busy, moving});
      SEL_SPI_ADDR:    prdata = word_t'(spi_addr_q);
      SEL_SPI_DATA:    prdata = spi_data_q;
      SEL_SPI_RX_ADDR: prdata = word_t'(rx_frame.addr);
      SEL_SPI_RX_DATA: prdata = rx_frame.data;
      SEL_LED:         prdata = word_t'(led_q);
      default:         prdata = '0;
    endcase
  end

  // ctrl bit0 is the enable and bit1 the direction
  assign drv_en = ctrl_q[0];
  assign move.start = move_start_q;
  assign move.dir = ctrl_q[1];
  assign move.period = period_q;
  assign move.count = count_q;
  assign spi.start = spi_start_q;
  assign spi.frame.addr = spi_addr_q;
  assign spi.frame.data = spi_data_q;
  assign led = led_q;

endmodule

`default_nettype wire

// ==== logic/stepper_top.sv ====
// motion peripheral top, connects the apb port and both engines to the board pins
`default_nettype none
`timescale 1ns/1ps

module stepper_top
  import stepper_pkg::*;
#(
  parameter int SPI_DIV = 4
) (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  // apb slave
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  paddr_t     paddr,
  input  word_t      pwdata,
  output word_t      prdata,
  output logic       pready,
  output logic       pslverr,
  // motor driver
  output logic       step,
  output logic       dir,
  output logic       drv_en,
  output logic       sck,
  output logic       cs_n,
  output logic       sdi,
  input  logic       sdo,
  output logic [3:0] led
);

  reg_access_t acc;
  move_cmd_t move;
  spi_cmd_t spi;
  logic moving;
  logic spi_busy;
  position_t position;
  spi_frame_t rx_frame;

  apb_decode u_decode (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .pready(pready), .pslverr(pslverr), .acc(acc)
  );

  control_regs u_regs (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n), .acc(acc),
    .moving(moving), .spi_busy(spi_busy),
    .position(position), .rx_frame(rx_frame),
    .prdata(prdata), .drv_en(drv_en),
    .move(move), .spi(spi), .led(led)
  );

  step_generator u_step (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n),
    .move(move), .drv_en(drv_en),
    .step(step), .dir(dir), .moving(moving), .position(position)
  );

  // driver config link
  spi_master #(
    .SPI_DIV(SPI_DIV)
  ) u_spi (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n), .spi(spi), .sdo(sdo),
    .sck(sck), .cs_n(cs_n), .sdi(sdi),
    .spi_busy(spi_busy), .rx_frame(rx_frame)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// testbench clock and reset source, 40 ns period with reset held low for the first cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_NS = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_25mhz,
  output logic rst_n
);

  // free running clock
  initial begin
    clk_25mhz = 1'b0;
    forever #(HALF_NS) clk_25mhz = ~clk_25mhz;
  end

  // release reset just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_25mhz);
    #2 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
// testbench monitor that watches the apb bus and motor pins and compares them with expected values
`default_nettype none
`timescale 1ns/1ps

module tb_checker
  import stepper_pkg::*;
(
  input wire logic       clk_25mhz,
  input wire logic       rst_n,
  input wire logic       psel,
  input wire logic       penable,
  input wire paddr_t     paddr,
  input wire word_t      prdata,
  input wire logic       pready,
  input wire logic       pslverr,
  input wire logic       step,
  input wire logic       dir,
  input wire logic       drv_en,
  input wire logic       sck,
  input wire logic       cs_n,
  input wire logic       sdi,
  input wire logic [3:0] led
);

  int case_errs = 0;
  int pass_count = 0;
  int fail_count = 0;
  int steps = 0;
  int steps_base = 0;
  int rises = 0;
  paddr_t last_addr = '0;
  word_t last_rdata = '0;
  logic last_err = 1'b0;
  logic last_ready = 1'b0;
  logic [3:0] last_led = '0;
  logic last_drv_en = 1'b0;
  logic last_dir = 1'b0;
  logic [39:0] tx_sh = '0;
  logic [39:0] tx_frame = '0;

  task automatic compare(input string what, input logic [39:0] got, input logic [39:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      case_errs = case_errs + 1;
    end
  endtask

  // case that could not run as written
  task automatic note_failure(input string what);
    $display("case problem: %s", what);
    case_errs = case_errs + 1;
  endtask

  // bus and pins captured mid access cycle when prdata has settled
  always @(negedge clk_25mhz) begin
    if (psel && penable) begin
      last_addr = paddr;
      last_rdata = prdata;
      last_err = pslverr;
      last_ready = pready;
      last_led = led;
      last_drv_en = drv_en;
      last_dir = dir;
    end
  end

  // every rising step edge counts
  always @(posedge step) begin
    if (rst_n) begin
      steps = steps + 1;
    end
  end

  // the driver samples sdi on rising sck in mode 3
  always @(posedge sck) begin
    if (!cs_n) begin
      tx_sh = {tx_sh[38:0], sdi};
      rises = rises + 1;
    end
  end

  always @(negedge cs_n) begin
    rises = 0;
  end

  always @(posedge cs_n) begin
    tx_frame = tx_sh;
  end

  task automatic check_access(input word_t exp_data, input logic exp_err, input logic use_data);
    compare("pready", 40'(last_ready), 40'(1'b1));
    compare("pslverr", 40'(last_err), 40'(exp_err));
    if (use_data || exp_err) begin
      compare("prdata", 40'(last_rdata), 40'(exp_err ? 32'h0 : exp_data));
    end
    // led, drv_en and dir pins follow the stored register bits
    if (use_data && !exp_err && (last_addr == REG_LED)) begin
      compare("led pins", 40'(last_led), 40'(exp_data[3:0]));
    end
    if (use_data && !exp_err && (last_addr == REG_CTRL)) begin
      compare("drv_en pin", 40'(last_drv_en), 40'(exp_data[0]));
      compare("dir pin", 40'(last_dir), 40'(exp_data[1]));
    end
  endtask

  // pulses since the previous move check
  task automatic check_steps(input int exp);
    compare("step pulses", 40'(steps - steps_base), 40'(exp));
    steps_base = steps;
  endtask

  task automatic check_frame(input logic [39:0] exp);
    compare("sck rising edges", 40'(rises), 40'(40));
    compare("sdi frame", tx_frame, exp);
  endtask

  task automatic check_reset_pins();
    compare("step after reset", 40'(step), 40'(1'b0));
    compare("dir after reset", 40'(dir), 40'(1'b0));
    compare("drv_en after reset", 40'(drv_en), 40'(1'b0));
    compare("cs_n after reset", 40'(cs_n), 40'(1'b1));
    compare("sck after reset", 40'(sck), 40'(1'b1));
    compare("led after reset", 40'(led), 40'(4'h0));
  endtask

  task automatic end_case(input int num, input byte op);
    if (case_errs == 0) begin
      pass_count = pass_count + 1;
      $display("case %0d (%c) ok", num, op);
    end else begin
      fail_count = fail_count + 1;
      $display("case %0d (%c) failed with %0d mismatches", num, op, case_errs);
    end
    case_errs = 0;
  endtask

  task automatic report();
    $display("cases run %0d, passed %0d, failed %0d",
             pass_count + fail_count, pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

// ==== testbench/tb_stepper.sv ====
// testbench top that replays the cases file over apb and models the smart driver on the spi pins
`default_nettype none
`timescale 1ns/1ps

module tb_stepper
  import stepper_pkg::*;
;

  localparam int SPI_DIV = 4;
  localparam int MAX_CASES = 64;

  logic clk_25mhz;
  logic rst_n;
  logic psel;
  logic penable;
  logic pwrite;
  paddr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic pready;
  logic pslverr;
  logic step;
  logic dir;
  logic drv_en;
  logic sck;
  logic cs_n;
  logic sdi;
  logic sdo;
  logic [3:0] led;

  // case table
  byte op_a [MAX_CASES];
  word_t addr_a [MAX_CASES];
  word_t data_a [MAX_CASES];
  word_t exp_a [MAX_CASES];
  logic err_a [MAX_CASES];
  int n_cases = 0;
  int limit = 0;
  int cycles = 0;
  spi_addr_t spi_addr_w = '0;
  // driver reply model
  logic [39:0] reply_q = '0;
  logic [39:0] reply_sh = '0;
  int falls = 0;

  tb_clock u_clk (.clk_25mhz(clk_25mhz), .rst_n(rst_n));

  stepper_top #(
    .SPI_DIV(SPI_DIV)
  ) UUT (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr),
    .step(step), .dir(dir), .drv_en(drv_en),
    .sck(sck), .cs_n(cs_n), .sdi(sdi), .sdo(sdo), .led(led)
  );

  tb_checker chk (
    .clk_25mhz(clk_25mhz), .rst_n(rst_n),
    .psel(psel), .penable(penable), .paddr(paddr),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .step(step), .dir(dir), .drv_en(drv_en),
    .sck(sck), .cs_n(cs_n), .sdi(sdi), .led(led)
  );

  // first reply bit is present as soon as cs_n falls
  always @(negedge cs_n) begin
    #2;
    falls = 0;
    reply_sh = reply_q;
    sdo = reply_sh[39];
  end

  // first falling edge keeps the msb while later ones advance
  always @(negedge sck) begin
    if (!cs_n) begin
      falls = falls + 1;
      if (falls > 1) begin
        #2;
        reply_sh = {reply_sh[38:0], 1'b0};
        sdo = reply_sh[39];
      end
    end
  end

  // hang guard
  always @(posedge clk_25mhz) begin
    cycles <= cycles + 1;
    if ((limit != 0) && (cycles > limit)) begin
      $display("timeout: run stopped after %0d cycles, a wait never completed", cycles);
      chk.report();
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic load_cases();
    int fd;
    int got;
    int rc;
    int per;
    int pc;
    int max_pc;
    int err_v;
    byte op;
    word_t a;
    word_t d;
    word_t e;
    string line;
    fd = $fopen("testbench/stepper_cases.txt", "r");
    per = 2;
    max_pc = 0;
    if (fd == 0) begin
      $display("could not open the cases file testbench/stepper_cases.txt");
    end else begin
      while (!$feof(fd) && (n_cases < MAX_CASES)) begin
        rc = $fgets(line, fd);
        if ((rc > 1) && (line[0] != "#")) begin
          got = $sscanf(line, "%c %h %h %h %d", op, a, d, e, err_v);
          if (got == 5) begin
            op_a[n_cases] = op;
            addr_a[n_cases] = a;
            data_a[n_cases] = d;
            exp_a[n_cases] = e;
            err_a[n_cases] = (err_v != 0);
            // longest move seen for the cycle limit
            if ((op == "W") && (a == 32'h04)) begin
              per = (d < 32'd2) ? 2 : int'(d[15:0]);
            end
            if ((op == "W") && (a == 32'h08)) begin
              pc = per * int'(d[15:0]);
              if (pc > max_pc) begin
                max_pc = pc;
              end
            end
            n_cases = n_cases + 1;
          end
        end
      end
      $fclose(fd);
    end
    limit = 16 + (n_cases + 1) * (max_pc + 80 * SPI_DIV + 2 + 200);
  endtask

  // one apb transfer with setup then access and no wait states
  task automatic apb_access(input logic wr, input word_t a, input word_t wd,
                            output word_t rd, output logic er);
    @(posedge clk_25mhz);
    #2;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = a[7:0];
    pwdata = wd;
    @(posedge clk_25mhz);
    #2;
    penable = 1'b1;
    @(negedge clk_25mhz);
    rd = prdata;
    er = pslverr;
    @(posedge clk_25mhz);
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // poll status until the chosen busy bit drops
  task automatic wait_status(input int b);
    word_t rd;
    logic er;
    rd = '1;
    while (rd[b]) begin
      apb_access(1'b0, 32'(REG_STATUS), 32'h0, rd, er);
    end
  endtask

  task automatic run_case(input int i);
    word_t rd;
    logic er;
    case (op_a[i])
      "W": begin
        apb_access(1'b1, addr_a[i], data_a[i], rd, er);
        if ((addr_a[i] == 32'(REG_SPI_ADDR)) && !err_a[i]) begin
          spi_addr_w = data_a[i][7:0];
        end
        chk.check_access(32'h0, err_a[i], 1'b0);
      end
      "R": begin
        apb_access(1'b0, addr_a[i], 32'h0, rd, er);
        chk.check_access(exp_a[i], err_a[i], 1'b1);
      end
      "M": begin
        wait_status(0);
        chk.check_steps(int'(exp_a[i]));
      end
      "S": begin
        // reply armed before the transfer starts
        reply_q = {addr_a[i][7:0], data_a[i]};
        apb_access(1'b1, 32'(REG_SPI_DATA), exp_a[i], rd, er);
        chk.check_access(32'h0, 1'b0, 1'b0);
        wait_status(1);
        chk.check_frame({spi_addr_w, exp_a[i]});
      end
      default: chk.note_failure("unknown operation in the cases file");
    endcase
  endtask

  initial begin
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    sdo = 1'b0;
    load_cases();
    @(posedge rst_n);
    @(negedge clk_25mhz);
    chk.check_reset_pins();
    chk.end_case(0, "P");
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
      chk.end_case(i + 1, op_a[i]);
    end
    chk.report();
    if ((chk.fail_count == 0) && (n_cases > 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/stepper_cases.txt ====
# op addr data expect err  (hex; err 1 = pslverr expected)
# W writes data, R checks expect, M checks step count, S: addr/data = reply, expect = tx word
R 00 00000000 00000000 0
R 04 00000000 00000000 0
R 08 00000000 00000000 0
R 0C 00000000 00000000 0
R 10 00000000 00000000 0
R 14 00000000 00000000 0
R 18 00000000 00000000 0
R 1C 00000000 00000000 0
R 20 00000000 00000000 0
R 24 00000000 00000000 0
W 24 0000000A 00000000 0
R 24 00000000 0000000A 0
W 04 00000005 00000000 0
W 08 00000003 00000000 0
M 00 00000000 00000000 0
W 00 00000003 00000000 0
R 00 00000000 00000003 0
W 08 00000003 00000000 0
M 00 00000000 00000003 0
R 0C 00000000 00000003 0
R 10 00000000 00000000 0
W 00 00000001 00000000 0
W 04 00000002 00000000 0
W 08 00000005 00000000 0
M 00 00000000 00000005 0
R 0C 00000000 FFFFFFFE 0
W 14 000000A5 00000000 0
S 3C 12345678 DEADBEEF 0
R 1C 00000000 0000003C 0
R 20 00000000 12345678 0
R 10 00000000 00000000 0
R 18 00000000 DEADBEEF 0
R 30 00000000 00000000 1
R 06 00000000 00000000 1
W 0C 00000055 00000000 1
R 0C 00000000 FFFFFFFE 0
W 28 000000FF 00000000 1
R 24 00000000 0000000A 0

// ==== verilog.f ====
common/stepper_pkg.sv
logic/apb_decode.sv
motion/step_generator.sv
spi/spi_master.sv
logic/control_regs.sv
logic/stepper_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_stepper.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the motion peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_stepper -o sim_stepper
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_stepper)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
